//--- rtl/dbg_pkg.sv
package dbg_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int unsigned DBG_ADDR_W       = 32;
    localparam int unsigned DBG_DATA_W       = 32;
    localparam int unsigned DBG_STRB_W       = 4;
    localparam int unsigned DBG_TAG_W        = 16;

    // region tags, matched against address bits 31:16
    localparam logic [DBG_TAG_W-1:0] DBG_ROM_BASE = 16'h0800;
    localparam logic [DBG_TAG_W-1:0] DBG_RAM_BASE = 16'h0801;
    localparam logic [DBG_TAG_W-1:0] DBG_LSU_BASE = 16'h0802;

    localparam int unsigned DBG_BUF_DEPTH    = 16;
    localparam int unsigned DBG_BUF_IDX_W    = $clog2(DBG_BUF_DEPTH);
    localparam int unsigned DBG_STATE_REGS   = 8;
    localparam int unsigned DBG_STATE_IDX_W  = $clog2(DBG_STATE_REGS);

    // request strobe to response strobe
    localparam int unsigned DBG_LATENCY      = 4;

    // program buffer park loop
    localparam logic [DBG_DATA_W-1:0] DBG_ROM_IMAGE [DBG_BUF_DEPTH] = '{
        32'h0ff0000f, 32'h7b241073, 32'hf1402473, 32'h10802023,
        32'h40044403, 32'h00147413, 32'h02041263, 32'hf1402473,
        32'h40044403, 32'h00247413, 32'hfc0418e3, 32'hfd5ff06f,
        32'h7b202473, 32'h10000023, 32'h7b200073, 32'h00100073
    };

    // ==================================================
    // types
    // ==================================================
    typedef enum logic [1:0] {
        TGT_ROM,
        TGT_RAM,
        TGT_LSU,
        TGT_NONE
    } dbg_target_e;

    typedef struct packed {
        logic [DBG_ADDR_W-1:0] addr;
        logic [DBG_DATA_W-1:0] data;
        logic [DBG_STRB_W-1:0] strb;
        logic                  write;
    } dbg_req_t;

    // original request kept beside the remapped address
    typedef struct packed {
        dbg_req_t              req;
        logic [DBG_ADDR_W-1:0] remap_addr;
    } dbg_remap_t;

    typedef struct packed {
        dbg_remap_t  remap;
        dbg_target_e tgt;
    } dbg_route_t;

    typedef struct packed {
        logic [DBG_DATA_W-1:0] data;
        logic                  err;
    } dbg_rsp_t;

endpackage

//--- rtl/dbg_addr_remap.sv
`timescale 1ns/1ps

module dbg_addr_remap
    import dbg_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  logic       req_vld,
    input  dbg_req_t   req,

    output logic       s1_vld,
    output dbg_remap_t s1
);

    logic [DBG_ADDR_W-1:0] remap_addr;

    // word index moves down to bits 3:0, bits 11:10 cleared
    assign remap_addr = {req.addr[DBG_ADDR_W-1:12], 2'b00, req.addr[11:2]};

    // ==================================================
    // stage 1 registers
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= req_vld;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (req_vld) begin
            s1.req        <= req;
            s1.remap_addr <= remap_addr;
        end
    end

endmodule

//--- rtl/dbg_region_decode.sv
`timescale 1ns/1ps

module dbg_region_decode
    import dbg_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  logic       s1_vld,
    input  dbg_remap_t s1,

    output logic       s2_vld,
    output dbg_route_t s2
);

    logic [DBG_TAG_W-1:0] tag;
    dbg_target_e          tgt_d;

    // region select on the remapped upper half
    assign tag = s1.remap_addr[DBG_ADDR_W-1 -: DBG_TAG_W];

    always_comb begin
        case (tag)
            DBG_ROM_BASE: begin
                tgt_d = TGT_ROM;
            end
            DBG_RAM_BASE: begin
                tgt_d = TGT_RAM;
            end
            DBG_LSU_BASE: begin
                tgt_d = TGT_LSU;
            end
            default: begin
                tgt_d = TGT_NONE;
            end
        endcase
    end

    // ==================================================
    // stage 2 registers
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_vld <= 1'b0;
        end else begin
            s2_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            s2.remap <= s1;
            s2.tgt   <= tgt_d;
        end
    end

endmodule

//--- rtl/dbg_prog_buf.sv
`timescale 1ns/1ps

module dbg_prog_buf
    import dbg_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  s2_vld,
    input  dbg_route_t            s2,

    output logic                  buf_vld,
    output logic [DBG_DATA_W-1:0] buf_data
);

    logic [DBG_DATA_W-1:0]    ram_q [DBG_BUF_DEPTH];
    logic [DBG_BUF_IDX_W-1:0] idx;
    logic                     rom_hit;
    logic                     ram_hit;

    // remapped address is already word aligned
    assign idx     = s2.remap.remap_addr[DBG_BUF_IDX_W-1:0];
    assign rom_hit = s2_vld && (s2.tgt == TGT_ROM);
    assign ram_hit = s2_vld && (s2.tgt == TGT_RAM);

    // ==================================================
    // debug ram
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DBG_BUF_DEPTH; i++) begin
                ram_q[i] <= '0;
            end
        end else if (ram_hit && s2.remap.req.write) begin
            // byte merge
            for (int b = 0; b < DBG_STRB_W; b++) begin
                if (s2.remap.req.strb[b]) begin
                    ram_q[idx][8*b +: 8] <= s2.remap.req.data[8*b +: 8];
                end
            end
        end
    end

    // ==================================================
    // read port
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_vld <= 1'b0;
        end else begin
            buf_vld <= rom_hit || ram_hit;
        end
    end

    // rom writes fall through here and are never stored
    always_ff @(posedge clk) begin
        if (rom_hit) begin
            buf_data <= DBG_ROM_IMAGE[idx];
        end else if (ram_hit) begin
            buf_data <= ram_q[idx];
        end
    end

endmodule

//--- rtl/dbg_state_regs.sv
`timescale 1ns/1ps

module dbg_state_regs
    import dbg_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  s2_vld,
    input  dbg_route_t            s2,

    output logic                  lsu_vld,
    output logic [DBG_DATA_W-1:0] lsu_data
);

    logic [DBG_DATA_W-1:0]      state_q [DBG_STATE_REGS];
    logic [DBG_STATE_IDX_W-1:0] idx;
    logic                       lsu_hit;

    // byte address, upper index bits alias
    assign idx     = s2.remap.req.addr[2 +: DBG_STATE_IDX_W];
    assign lsu_hit = s2_vld && (s2.tgt == TGT_LSU);

    // ==================================================
    // hart state registers
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DBG_STATE_REGS; i++) begin
                state_q[i] <= '0;
            end
        end else if (lsu_hit && s2.remap.req.write) begin
            for (int b = 0; b < DBG_STRB_W; b++) begin
                if (s2.remap.req.strb[b]) begin
                    state_q[idx][8*b +: 8] <= s2.remap.req.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lsu_vld <= 1'b0;
        end else begin
            lsu_vld <= lsu_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_hit) begin
            lsu_data <= state_q[idx];
        end
    end

endmodule

//--- rtl/dbg_rsp_merge.sv
`timescale 1ns/1ps

module dbg_rsp_merge
    import dbg_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  s2_vld,
    input  dbg_route_t            s2,
    input  logic                  buf_vld,
    input  logic                  lsu_vld,
    input  logic [DBG_DATA_W-1:0] buf_data,
    input  logic [DBG_DATA_W-1:0] lsu_data,

    output logic                  rsp_vld,
    output dbg_rsp_t              rsp
);

    logic                  al_vld;
    logic                  al_none;
    logic                  al_write;
    logic [DBG_DATA_W-1:0] merged;

    // line up with the stage 3 target outputs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            al_vld   <= 1'b0;
            al_none  <= 1'b0;
            al_write <= 1'b0;
        end else begin
            al_vld   <= s2_vld;
            al_none  <= s2_vld && (s2.tgt == TGT_NONE);
            al_write <= s2_vld && s2.remap.req.write;
        end
    end

    // at most one target valid per cycle
    assign merged = ({DBG_DATA_W{buf_vld}} & buf_data) | ({DBG_DATA_W{lsu_vld}} & lsu_data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_vld  <= 1'b0;
            rsp      <= '0;
        end else begin
            rsp_vld  <= al_vld;
            rsp.err  <= al_none;
            rsp.data <= al_write ? '0 : merged;
        end
    end

endmodule

//--- rtl/debug_access_path.sv
`timescale 1ns/1ps

module debug_access_path
    import dbg_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     req_vld,
    input  dbg_req_t req,

    output logic     rsp_vld,
    output dbg_rsp_t rsp
);

    logic                  s1_vld;
    dbg_remap_t            s1;
    logic                  s2_vld;
    dbg_route_t            s2;
    logic                  buf_vld;
    logic [DBG_DATA_W-1:0] buf_data;
    logic                  lsu_vld;
    logic [DBG_DATA_W-1:0] lsu_data;

    // ==================================================
    // request path
    // ==================================================
    dbg_addr_remap u_remap (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_vld (req_vld),
        .req     (req),
        .s1_vld  (s1_vld),
        .s1      (s1)
    );

    dbg_region_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .s1_vld (s1_vld),
        .s1     (s1),
        .s2_vld (s2_vld),
        .s2     (s2)
    );

    // ==================================================
    // targets and response
    // ==================================================
    dbg_prog_buf u_prog_buf (
        .clk      (clk),
        .arst_n   (arst_n),
        .s2_vld   (s2_vld),
        .s2       (s2),
        .buf_vld  (buf_vld),
        .buf_data (buf_data)
    );

    dbg_state_regs u_state_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .s2_vld   (s2_vld),
        .s2       (s2),
        .lsu_vld  (lsu_vld),
        .lsu_data (lsu_data)
    );

    dbg_rsp_merge u_merge (
        .clk      (clk),
        .arst_n   (arst_n),
        .s2_vld   (s2_vld),
        .s2       (s2),
        .buf_vld  (buf_vld),
        .lsu_vld  (lsu_vld),
        .buf_data (buf_data),
        .lsu_data (lsu_data),
        .rsp_vld  (rsp_vld),
        .rsp      (rsp)
    );

endmodule

//--- verif/debug_access_path_chk.sv
`timescale 1ns/1ps

module debug_access_path_chk
    import dbg_pkg::*;
(
    input logic     clk,
    input logic     arst_n,
    input logic     req_vld,
    input logic     rsp_vld,
    input dbg_rsp_t rsp
);

    // ==================================================
    // port level properties
    // ==================================================
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_vld == $past(req_vld, DBG_LATENCY))
        else $error("rsp_vld does not follow req_vld by the pipeline latency");

    // error responses carry no data
    a_err_data: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_vld && rsp.err) |-> (rsp.data == '0))
        else $error("error response with nonzero data");

    a_quiet_reset: assert property (@(posedge clk)
        !arst_n |-> !rsp_vld)
        else $error("rsp_vld high while in reset");

endmodule

bind debug_access_path debug_access_path_chk u_chk (
    .clk     (clk),
    .arst_n  (arst_n),
    .req_vld (req_vld),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
);

//--- verif/debug_access_path_tb.sv
`timescale 1ns/1ps

module debug_access_path_tb
    import dbg_pkg::*;
();

    logic     clk;
    logic     arst_n;
    logic     req_vld;
    dbg_req_t req;
    logic     rsp_vld;
    dbg_rsp_t rsp;

    int unsigned num_cycles = 2000;
    integer      seed;
    int          cyc;
    int          n_rsp;
    int          val_errors;
    int          proto_errors;

    // reference copies of the writable storage
    logic [DBG_DATA_W-1:0] ram_model   [DBG_BUF_DEPTH];
    logic [DBG_DATA_W-1:0] state_model [DBG_STATE_REGS];

    // expected responses, with the negedge count at which each is due
    dbg_rsp_t exp_rsp_q [$];
    int       exp_due_q [$];

    debug_access_path uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_vld (req_vld),
        .req     (req),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    always #10 clk = ~clk;

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic [DBG_DATA_W-1:0] merge_bytes(
        input logic [DBG_DATA_W-1:0] old_word,
        input logic [DBG_DATA_W-1:0] wdata,
        input logic [DBG_STRB_W-1:0] strb
    );
        logic [DBG_DATA_W-1:0] res;
        res = old_word;
        for (int b = 0; b < DBG_STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic model_access(input dbg_req_t r, output dbg_rsp_t e);
        logic [DBG_TAG_W-1:0]       tag;
        logic [DBG_BUF_IDX_W-1:0]   widx;
        logic [DBG_STATE_IDX_W-1:0] sidx;
        tag    = r.addr[31:16];
        widx   = r.addr[5:2];
        sidx   = r.addr[4:2];
        e.err  = 1'b0;
        e.data = '0;
        case (tag)
            DBG_ROM_BASE: begin
                if (!r.write) begin
                    e.data = DBG_ROM_IMAGE[widx];
                end
            end
            DBG_RAM_BASE: begin
                if (r.write) begin
                    ram_model[widx] = merge_bytes(ram_model[widx], r.data, r.strb);
                end else begin
                    e.data = ram_model[widx];
                end
            end
            DBG_LSU_BASE: begin
                if (r.write) begin
                    state_model[sidx] = merge_bytes(state_model[sidx], r.data, r.strb);
                end else begin
                    e.data = state_model[sidx];
                end
            end
            default: begin
                e.err = 1'b1;
            end
        endcase
    endtask

    // ==================================================
    // stimulus and checks
    // ==================================================
    function automatic logic [DBG_ADDR_W-1:0] pick_addr();
        logic [31:0]          rnd;
        logic [DBG_TAG_W-1:0] tag;
        int                   sel;
        sel = {$random(seed)} % 4;
        case (sel)
            0: tag = DBG_ROM_BASE;
            1: tag = DBG_RAM_BASE;
            2: tag = DBG_LSU_BASE;
            default: begin
                rnd = $random(seed);
                tag = rnd[15:0];
                // keep clear of the mapped tags
                while (tag == DBG_ROM_BASE || tag == DBG_RAM_BASE || tag == DBG_LSU_BASE) begin
                    rnd = $random(seed);
                    tag = rnd[15:0];
                end
            end
        endcase
        rnd = $random(seed);
        return {tag, rnd[15:0]};
    endfunction

    task automatic check_response();
        dbg_rsp_t exp;
        if (exp_due_q.size() > 0 && exp_due_q[0] == cyc) begin
            exp = exp_rsp_q.pop_front();
            void'(exp_due_q.pop_front());
            n_rsp++;
            if (rsp_vld !== 1'b1) begin
                proto_errors++;
                $display("no response at cycle %0d although a request was due", cyc);
            end else begin
                if (rsp.err !== exp.err) begin
                    val_errors++;
                    $display("FAIL rsp.err: got %h, expected %h at cycle %0d",
                             rsp.err, exp.err, cyc);
                end
                if (rsp.data !== exp.data) begin
                    val_errors++;
                    $display("FAIL rsp.data: got %h, expected %h at cycle %0d",
                             rsp.data, exp.data, cyc);
                end
            end
        end else if (rsp_vld !== 1'b0) begin
            proto_errors++;
            $display("response at cycle %0d without any request due", cyc);
        end
    endtask

    task automatic step(input bit allow_req);
        dbg_req_t    r;
        dbg_rsp_t    e;
        logic [31:0] rnd;
        int          roll;
        @(negedge clk);
        cyc++;
        check_response();
        roll = {$random(seed)} % 4;
        if (allow_req && roll != 0) begin
            r.addr  = pick_addr();
            r.data  = $random(seed);
            rnd     = $random(seed);
            r.strb  = rnd[3:0];
            r.write = rnd[4];
            model_access(r, e);
            exp_rsp_q.push_back(e);
            exp_due_q.push_back(cyc + DBG_LATENCY);
            req_vld = 1'b1;
            req     = r;
        end else begin
            req_vld = 1'b0;
            req     = '0;
        end
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        req_vld      = 1'b0;
        req          = '0;
        seed         = 32'hf1f1;
        cyc          = 0;
        n_rsp        = 0;
        val_errors   = 0;
        proto_errors = 0;
        for (int i = 0; i < DBG_BUF_DEPTH; i++) begin
            ram_model[i] = '0;
        end
        for (int i = 0; i < DBG_STATE_REGS; i++) begin
            state_model[i] = '0;
        end

        repeat (10) begin
            @(negedge clk);
            if (rsp_vld !== 1'b0) begin
                proto_errors++;
                $display("rsp_vld is not low during reset");
            end
        end
        arst_n = 1'b1;

        for (int n = 0; n < num_cycles; n++) begin
            step(1'b1);
        end
        // drain the pipeline
        repeat (DBG_LATENCY + 2) begin
            step(1'b0);
        end
        if (exp_due_q.size() != 0) begin
            proto_errors++;
            $display("%0d responses never arrived", exp_due_q.size());
        end

        $display("responses checked %0d, value errors %0d, protocol errors %0d",
                 n_rsp, val_errors, proto_errors);
        if (val_errors == 0 && proto_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((num_cycles + 50) * 20);
        $display("watchdog expired before the test finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- vlog.f
rtl/dbg_pkg.sv
rtl/dbg_addr_remap.sv
rtl/dbg_region_decode.sv
rtl/dbg_prog_buf.sv
rtl/dbg_state_regs.sv
rtl/dbg_rsp_merge.sv
rtl/debug_access_path.sv
verif/debug_access_path_chk.sv
verif/debug_access_path_tb.sv

//--- Makefile
# Verilator build and run for the debug access path testbench

TOP = debug_access_path_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
